//--- core_pkg.sv
package core_pkg;

    localparam int NUM_WARPS = 4;
    localparam int THREADS_PER_WARP = 4;
    localparam int DATA_WIDTH = 16;
    localparam int IADDR_WIDTH = 8;
    localparam int DADDR_WIDTH = 8;
    localparam int NUM_REGS = 16;
    localparam int REG_IDX_WIDTH = $clog2(NUM_REGS);
    localparam int WARP_IDX_WIDTH = $clog2(NUM_WARPS);

    // Read-only registers at the top of each lane's register space
    localparam int REG_BLOCK_DIM = 13;
    localparam int REG_BLOCK_ID = 14;
    localparam int REG_THREAD_ID = 15;

    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [IADDR_WIDTH-1:0] iaddr_t;
    typedef logic [DADDR_WIDTH-1:0] daddr_t;
    typedef logic [REG_IDX_WIDTH-1:0] reg_idx_t;
    typedef logic [WARP_IDX_WIDTH-1:0] warp_idx_t;

    typedef enum logic [3:0] {
        NOP   = 4'h0,
        ADD   = 4'h1,
        SUB   = 4'h2,
        MUL   = 4'h3,
        ADDI  = 4'h4,
        CONST = 4'h5,
        STORE = 4'h6,
        HALT  = 4'hf
    } opcode_t;

    typedef enum logic [2:0] {
        WARP_IDLE,
        WARP_FETCH,
        WARP_DECODE,
        WARP_EXECUTE,
        WARP_STORE,
        WARP_UPDATE,
        WARP_DONE
    } warp_state_t;

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_REQUEST,
        FETCH_DONE
    } fetch_state_t;

    // Opcode sits in the top four bits of the word
    typedef struct packed {
        opcode_t  opcode;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        data_t    imm;
    } instruction_t;

    typedef struct packed {
        opcode_t  opcode;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        data_t    imm;
        logic     reg_write;
    } decoded_t;

    typedef struct packed {
        iaddr_t     base_address;
        logic [2:0] num_warps;
    } kernel_config_t;

    typedef struct packed {
        logic   valid;
        iaddr_t address;
    } imem_req_t;

    typedef data_t [THREADS_PER_WARP-1:0] lane_data_t;

    typedef struct packed {
        logic                               valid;
        daddr_t [THREADS_PER_WARP-1:0]      address;
        lane_data_t                         data;
    } store_req_t;

endpackage

//--- fetcher.sv
`timescale 1ns/1ns

module fetcher (
    input  logic                  clk,
    input  logic                  reset,
    input  core_pkg::warp_state_t warp_state,
    input  core_pkg::iaddr_t      pc,
    input  logic                  imem_ready,
    input  core_pkg::instruction_t imem_data,
    output core_pkg::imem_req_t   imem_req,
    output logic                  fetch_done,
    output core_pkg::instruction_t instruction
);

    core_pkg::fetch_state_t state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= core_pkg::FETCH_IDLE;
        end else begin
            case (state)
                core_pkg::FETCH_IDLE: begin
                    if (warp_state == core_pkg::WARP_FETCH) begin
                        state <= core_pkg::FETCH_REQUEST;
                    end
                end
                core_pkg::FETCH_REQUEST: begin
                    // Word is only valid in the handshake cycle
                    if (imem_ready) begin
                        instruction <= imem_data;
                        state <= core_pkg::FETCH_DONE;
                    end
                end
                default: begin
                    if (warp_state != core_pkg::WARP_FETCH) begin
                        state <= core_pkg::FETCH_IDLE;
                    end
                end
            endcase
        end
    end

    assign imem_req.valid = (state == core_pkg::FETCH_REQUEST);
    assign imem_req.address = pc;

    // Raised in the handshake cycle so the warp decodes on the next one
    assign fetch_done = (state == core_pkg::FETCH_REQUEST && imem_ready) ||
                        (state == core_pkg::FETCH_DONE);

endmodule

//--- decoder.sv
`timescale 1ns/1ns

module decoder (
    input  logic                   clk,
    input  logic                   reset,
    input  core_pkg::warp_state_t  warp_state,
    input  core_pkg::instruction_t instruction,
    output core_pkg::decoded_t     decoded
);

    always_ff @(posedge clk) begin
        if (reset) begin
            decoded <= '0;
        end else if (warp_state == core_pkg::WARP_DECODE) begin
            decoded.rd <= instruction.rd;
            decoded.rs1 <= instruction.rs1;
            decoded.rs2 <= instruction.rs2;
            decoded.imm <= instruction.imm;
            case (instruction.opcode)
                core_pkg::ADD,
                core_pkg::SUB,
                core_pkg::MUL,
                core_pkg::ADDI,
                core_pkg::CONST: begin
                    decoded.opcode <= instruction.opcode;
                    decoded.reg_write <= 1'b1;
                end
                core_pkg::STORE,
                core_pkg::HALT: begin
                    decoded.opcode <= instruction.opcode;
                    decoded.reg_write <= 1'b0;
                end
                default: begin
                    // Anything unrecognised behaves as a NOP
                    decoded.opcode <= core_pkg::NOP;
                    decoded.reg_write <= 1'b0;
                end
            endcase
        end
    end

endmodule

//--- warp_scheduler.sv
`timescale 1ns/1ns

module warp_scheduler (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         start,
    input  core_pkg::kernel_config_t     kernel_config,
    input  logic [core_pkg::NUM_WARPS-1:0] fetch_done,
    input  core_pkg::decoded_t           decoded,
    input  logic                         store_done,
    output core_pkg::warp_state_t        warp_state [core_pkg::NUM_WARPS],
    output core_pkg::iaddr_t             pc [core_pkg::NUM_WARPS],
    output core_pkg::warp_idx_t          current_warp,
    output logic                         done
);

    logic active;
    logic all_done;
    logic found;
    core_pkg::warp_idx_t next_warp;
    core_pkg::warp_state_t current_state;

    assign current_state = warp_state[current_warp];

    // Round-robin search over the other warps, starting after the current one
    always_comb begin
        core_pkg::warp_idx_t idx;
        found = 1'b0;
        next_warp = current_warp;
        for (int i = 1; i < core_pkg::NUM_WARPS; i++) begin
            idx = core_pkg::warp_idx_t'(current_warp + i);
            if (!found && warp_state[idx] inside {core_pkg::WARP_DECODE,
                    core_pkg::WARP_EXECUTE, core_pkg::WARP_STORE, core_pkg::WARP_UPDATE}) begin
                found = 1'b1;
                next_warp = idx;
            end
        end
    end

    always_comb begin
        all_done = 1'b1;
        for (int i = 0; i < core_pkg::NUM_WARPS; i++) begin
            if (i < kernel_config.num_warps && warp_state[i] != core_pkg::WARP_DONE) begin
                all_done = 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            active <= 1'b0;
            done <= 1'b0;
            current_warp <= '0;
            for (int i = 0; i < core_pkg::NUM_WARPS; i++) begin
                warp_state[i] <= core_pkg::WARP_IDLE;
                pc[i] <= '0;
            end
        end else if (!active) begin
            if (start) begin
                active <= 1'b1;
                current_warp <= '0;
                for (int i = 0; i < core_pkg::NUM_WARPS; i++) begin
                    if (i < kernel_config.num_warps) begin
                        warp_state[i] <= core_pkg::WARP_FETCH;
                        pc[i] <= kernel_config.base_address;
                    end
                end
            end
        end else begin
            if (all_done) begin
                done <= 1'b1;
            end

            // Fetches complete independently of the current warp
            for (int i = 0; i < core_pkg::NUM_WARPS; i++) begin
                if (warp_state[i] == core_pkg::WARP_FETCH && fetch_done[i]) begin
                    warp_state[i] <= core_pkg::WARP_DECODE;
                end
            end

            if ((current_state == core_pkg::WARP_UPDATE ||
                 current_state == core_pkg::WARP_DONE) && found) begin
                current_warp <= next_warp;
            end

            case (current_state)
                core_pkg::WARP_DECODE: begin
                    warp_state[current_warp] <= core_pkg::WARP_EXECUTE;
                end
                core_pkg::WARP_EXECUTE: begin
                    warp_state[current_warp] <= (decoded.opcode == core_pkg::STORE) ?
                        core_pkg::WARP_STORE : core_pkg::WARP_UPDATE;
                end
                core_pkg::WARP_STORE: begin
                    if (store_done) begin
                        warp_state[current_warp] <= core_pkg::WARP_UPDATE;
                    end
                end
                core_pkg::WARP_UPDATE: begin
                    if (decoded.opcode == core_pkg::HALT) begin
                        warp_state[current_warp] <= core_pkg::WARP_DONE;
                    end else begin
                        pc[current_warp] <= pc[current_warp] + 1'b1;
                        warp_state[current_warp] <= core_pkg::WARP_FETCH;
                    end
                end
                default: begin
                end
            endcase
        end
    end

endmodule

//--- vector_reg_file.sv
`timescale 1ns/1ns

module vector_reg_file (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     start,
    input  core_pkg::kernel_config_t kernel_config,
    input  core_pkg::data_t          block_id,
    input  core_pkg::warp_idx_t      current_warp,
    input  core_pkg::warp_state_t    current_state,
    input  core_pkg::decoded_t       decoded,
    input  core_pkg::lane_data_t     alu_out,
    output core_pkg::lane_data_t     rs1_data,
    output core_pkg::lane_data_t     rs2_data
);

    core_pkg::data_t regs [core_pkg::NUM_WARPS][core_pkg::THREADS_PER_WARP][core_pkg::NUM_REGS];

    function automatic core_pkg::data_t read_lane(input int lane, input core_pkg::reg_idx_t idx);
        core_pkg::data_t value;
        case (idx)
            core_pkg::REG_THREAD_ID:
                value = core_pkg::data_t'(current_warp * core_pkg::THREADS_PER_WARP + lane);
            core_pkg::REG_BLOCK_ID:
                value = block_id;
            core_pkg::REG_BLOCK_DIM:
                value = core_pkg::data_t'(kernel_config.num_warps * core_pkg::THREADS_PER_WARP);
            default:
                value = regs[current_warp][lane][idx];
        endcase
        return value;
    endfunction

    always_comb begin
        for (int l = 0; l < core_pkg::THREADS_PER_WARP; l++) begin
            rs1_data[l] = read_lane(l, decoded.rs1);
            rs2_data[l] = read_lane(l, decoded.rs2);
        end
    end

    always_ff @(posedge clk) begin
        if (reset || start) begin
            for (int w = 0; w < core_pkg::NUM_WARPS; w++) begin
                for (int l = 0; l < core_pkg::THREADS_PER_WARP; l++) begin
                    for (int r = 0; r < core_pkg::NUM_REGS; r++) begin
                        regs[w][l][r] <= '0;
                    end
                end
            end
        end else if (current_state == core_pkg::WARP_EXECUTE && decoded.reg_write &&
                     decoded.rd < core_pkg::REG_BLOCK_DIM) begin
            // Special registers from REG_BLOCK_DIM up are never written
            for (int l = 0; l < core_pkg::THREADS_PER_WARP; l++) begin
                regs[current_warp][l][decoded.rd] <= alu_out[l];
            end
        end
    end

endmodule

//--- vector_alu.sv
`timescale 1ns/1ns

module vector_alu (
    input  core_pkg::decoded_t   decoded,
    input  core_pkg::lane_data_t rs1_data,
    input  core_pkg::lane_data_t rs2_data,
    output core_pkg::lane_data_t alu_out
);

    // One adder and multiplier per lane with a shared opcode
    always_comb begin
        for (int l = 0; l < core_pkg::THREADS_PER_WARP; l++) begin
            case (decoded.opcode)
                core_pkg::ADD:   alu_out[l] = rs1_data[l] + rs2_data[l];
                core_pkg::SUB:   alu_out[l] = rs1_data[l] - rs2_data[l];
                core_pkg::MUL:   alu_out[l] = rs1_data[l] * rs2_data[l];
                core_pkg::ADDI:  alu_out[l] = rs1_data[l] + decoded.imm;
                core_pkg::CONST: alu_out[l] = decoded.imm;
                default:         alu_out[l] = '0;
            endcase
        end
    end

endmodule

//--- store_unit.sv
`timescale 1ns/1ns

module store_unit (
    input  logic                  clk,
    input  logic                  reset,
    input  core_pkg::warp_state_t current_state,
    input  core_pkg::decoded_t    decoded,
    input  core_pkg::lane_data_t  rs1_data,
    input  core_pkg::lane_data_t  rs2_data,
    input  logic                  dmem_ready,
    output core_pkg::store_req_t  dmem_store,
    output logic                  store_done
);

    always_ff @(posedge clk) begin
        if (reset) begin
            dmem_store.valid <= 1'b0;
            store_done <= 1'b0;
        end else begin
            store_done <= 1'b0;
            if (dmem_store.valid) begin
                if (dmem_ready) begin
                    dmem_store.valid <= 1'b0;
                    store_done <= 1'b1;
                end
            end else if (current_state == core_pkg::WARP_EXECUTE &&
                         decoded.opcode == core_pkg::STORE) begin
                // Captured as the warp moves into WARP_STORE
                dmem_store.valid <= 1'b1;
                for (int l = 0; l < core_pkg::THREADS_PER_WARP; l++) begin
                    dmem_store.address[l] <= core_pkg::daddr_t'(rs1_data[l] + decoded.imm);
                    dmem_store.data[l] <= rs2_data[l];
                end
            end
        end
    end

endmodule

//--- compute_core.sv
`timescale 1ns/1ns

module compute_core (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           start,
    input  core_pkg::data_t                block_id,
    input  core_pkg::kernel_config_t       kernel_config,
    input  logic [core_pkg::NUM_WARPS-1:0] imem_ready,
    input  core_pkg::instruction_t         imem_data [core_pkg::NUM_WARPS],
    output core_pkg::imem_req_t            imem_req [core_pkg::NUM_WARPS],
    input  logic                           dmem_ready,
    output core_pkg::store_req_t           dmem_store,
    output logic                           done
);

    core_pkg::warp_state_t        warp_state [core_pkg::NUM_WARPS];
    core_pkg::iaddr_t             pc [core_pkg::NUM_WARPS];
    logic [core_pkg::NUM_WARPS-1:0] fetch_done;
    core_pkg::instruction_t       fetched [core_pkg::NUM_WARPS];
    core_pkg::decoded_t           decoded [core_pkg::NUM_WARPS];
    core_pkg::warp_idx_t          current_warp;
    core_pkg::warp_state_t        current_state;
    core_pkg::decoded_t           current_decoded;
    core_pkg::lane_data_t         rs1_data;
    core_pkg::lane_data_t         rs2_data;
    core_pkg::lane_data_t         alu_out;
    logic                         store_done;

    // Shared units only ever see the warp that owns the pipeline
    assign current_state = warp_state[current_warp];
    assign current_decoded = decoded[current_warp];

    warp_scheduler scheduler_inst (
        .clk(clk), .reset(reset), .start(start),
        .kernel_config(kernel_config),
        .fetch_done(fetch_done),
        .decoded(current_decoded),
        .store_done(store_done),
        .warp_state(warp_state),
        .pc(pc),
        .current_warp(current_warp),
        .done(done)
    );

    for (genvar i = 0; i < core_pkg::NUM_WARPS; i++) begin : g_warp
        fetcher fetcher_inst (
            .clk(clk), .reset(reset),
            .warp_state(warp_state[i]),
            .pc(pc[i]),
            .imem_ready(imem_ready[i]),
            .imem_data(imem_data[i]),
            .imem_req(imem_req[i]),
            .fetch_done(fetch_done[i]),
            .instruction(fetched[i])
        );

        decoder decoder_inst (
            .clk(clk), .reset(reset),
            .warp_state(warp_state[i]),
            .instruction(fetched[i]),
            .decoded(decoded[i])
        );
    end

    vector_reg_file reg_file_inst (
        .clk(clk), .reset(reset), .start(start),
        .kernel_config(kernel_config),
        .block_id(block_id),
        .current_warp(current_warp),
        .current_state(current_state),
        .decoded(current_decoded),
        .alu_out(alu_out),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data)
    );

    vector_alu alu_inst (
        .decoded(current_decoded),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .alu_out(alu_out)
    );

    store_unit store_inst (
        .clk(clk), .reset(reset),
        .current_state(current_state),
        .decoded(current_decoded),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .dmem_ready(dmem_ready),
        .dmem_store(dmem_store),
        .store_done(store_done)
    );

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    localparam int HALF_PERIOD = 20;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Power-on reset spans the first three rising edges
    initial begin
        reset = 1'b1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

//--- tb_compute_core.sv
`timescale 1ns/1ns

module tb_compute_core;

    localparam int PROG_LEN = 7;
    localparam int SECOND_STORE_BASE = 24;
    localparam int RESET_TIMEOUT = 20;
    localparam int DONE_TIMEOUT = 5000;
    localparam logic [31:0] LFSR_SEED = 32'h9966252f;
    localparam int LANES = core_pkg::THREADS_PER_WARP;
    localparam int WARPS = core_pkg::NUM_WARPS;

    logic clk;
    logic power_on_reset;
    logic soft_reset;
    logic reset;
    logic start;
    core_pkg::data_t block_id;
    core_pkg::kernel_config_t kernel_config;
    logic [WARPS-1:0] imem_ready;
    core_pkg::instruction_t imem_data [WARPS];
    core_pkg::imem_req_t imem_req [WARPS];
    logic dmem_ready;
    core_pkg::store_req_t dmem_store;
    logic done;

    logic started;
    logic any_fetch_valid;
    logic [WARPS-1:0] fetch_addr_good;
    logic store_good;
    logic stores_all_done;
    logic [31:0] lfsr = LFSR_SEED;
    core_pkg::iaddr_t expected_addr [WARPS];
    logic [1:0] store_count [WARPS];
    core_pkg::instruction_t program_rom [PROG_LEN];
    int error_count = 0;
    int timeout_count = 0;

    assign reset = power_on_reset || soft_reset;

    tb_clock_gen clock_gen (
        .clk(clk),
        .reset(power_on_reset)
    );

    compute_core dut (
        .clk(clk),
        .reset(reset),
        .start(start),
        .block_id(block_id),
        .kernel_config(kernel_config),
        .imem_ready(imem_ready),
        .imem_data(imem_data),
        .imem_req(imem_req),
        .dmem_ready(dmem_ready),
        .dmem_store(dmem_store),
        .done(done)
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h80200003;
        end else begin
            return state >> 1;
        end
    endfunction

    function automatic core_pkg::instruction_t encode(input core_pkg::opcode_t op, input int rd,
                                                      input int rs1, input int rs2, input int imm);
        core_pkg::instruction_t word;
        word.opcode = op;
        word.rd = core_pkg::reg_idx_t'(rd);
        word.rs1 = core_pkg::reg_idx_t'(rs1);
        word.rs2 = core_pkg::reg_idx_t'(rs2);
        word.imm = core_pkg::data_t'(imm);
        return word;
    endfunction

    // Kernel shared by every warp and lane
    initial begin
        program_rom[0] = encode(core_pkg::CONST, 1, 0, 0, 3);
        program_rom[1] = encode(core_pkg::ADD, 2, 15, 14, 0);
        program_rom[2] = encode(core_pkg::MUL, 3, 2, 1, 0);
        program_rom[3] = encode(core_pkg::ADDI, 4, 15, 0, 8);
        program_rom[4] = encode(core_pkg::STORE, 0, 15, 3, 0);
        program_rom[5] = encode(core_pkg::STORE, 0, 4, 2, 16);
        program_rom[6] = encode(core_pkg::HALT, 0, 0, 0, 0);
    end

    // Lane 0 tells which warp and which of the two stores this is
    function automatic int store_warp(input core_pkg::store_req_t req);
        int thread;
        if (req.address[0] >= SECOND_STORE_BASE) begin
            thread = req.address[0] - SECOND_STORE_BASE;
        end else begin
            thread = req.address[0];
        end
        return thread / LANES;
    endfunction

    function automatic logic store_matches(input core_pkg::store_req_t req);
        logic ok;
        logic second;
        int warp;
        int thread;
        int exp_addr;
        int exp_data;
        ok = 1'b1;
        second = (req.address[0] >= SECOND_STORE_BASE);
        warp = store_warp(req);
        if (warp >= kernel_config.num_warps) begin
            ok = 1'b0;
        end else if (store_count[warp] != (second ? 2'd1 : 2'd0)) begin
            ok = 1'b0;
        end
        for (int l = 0; l < LANES; l++) begin
            thread = warp * LANES + l;
            if (second) begin
                exp_addr = thread + SECOND_STORE_BASE;
                exp_data = thread + block_id;
            end else begin
                exp_addr = thread;
                exp_data = 3 * (thread + block_id);
            end
            if (req.address[l] != core_pkg::daddr_t'(exp_addr) ||
                req.data[l] != core_pkg::data_t'(exp_data)) begin
                ok = 1'b0;
            end
        end
        return ok;
    endfunction

    function automatic logic stores_complete();
        logic ok;
        ok = 1'b1;
        for (int w = 0; w < WARPS; w++) begin
            if (store_count[w] != ((w < kernel_config.num_warps) ? 2'd2 : 2'd0)) begin
                ok = 1'b0;
            end
        end
        return ok;
    endfunction

    function automatic logic fetch_addr_ok(input core_pkg::iaddr_t address,
                                           input core_pkg::iaddr_t expected,
                                           input core_pkg::iaddr_t base);
        core_pkg::iaddr_t offset;
        offset = address - base;
        return (address == expected) && (offset < PROG_LEN);
    endfunction

    task automatic flag_error(input string msg);
        error_count++;
        $display("Error at %0t ns: %s", $time, msg);
    endtask

    // Per-cycle check results read by the assertions below
    always_comb begin
        any_fetch_valid = 1'b0;
        for (int w = 0; w < WARPS; w++) begin
            any_fetch_valid = any_fetch_valid | imem_req[w].valid;
            fetch_addr_good[w] = fetch_addr_ok(imem_req[w].address, expected_addr[w],
                                               kernel_config.base_address);
        end
        store_good = store_matches(dmem_store);
        stores_all_done = stores_complete();
    end

    // Instruction memory and random back-pressure with one LFSR step per ready bit
    always @(posedge clk) begin : memory_model
        core_pkg::iaddr_t offset;
        for (int w = 0; w < WARPS; w++) begin
            offset = imem_req[w].address - kernel_config.base_address;
            if (offset < PROG_LEN) begin
                imem_data[w] <= program_rom[offset];
            end else begin
                imem_data[w] <= '0;
            end
            imem_ready[w] <= lfsr[0];
            lfsr = lfsr_step(lfsr);
        end
        dmem_ready <= lfsr[0];
        lfsr = lfsr_step(lfsr);
    end

    // Next expected fetch address and accepted stores per warp
    always @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < WARPS; w++) begin
                expected_addr[w] <= '0;
                store_count[w] <= '0;
            end
        end else begin
            for (int w = 0; w < WARPS; w++) begin
                if (start) begin
                    expected_addr[w] <= kernel_config.base_address;
                end else if (imem_req[w].valid && imem_ready[w]) begin
                    expected_addr[w] <= expected_addr[w] + 8'd1;
                end
            end
            if (dmem_store.valid && dmem_ready && store_warp(dmem_store) < WARPS) begin
                store_count[store_warp(dmem_store)] <= store_count[store_warp(dmem_store)] + 2'd1;
            end
        end
    end

    a_quiet_before_start: assert property (@(posedge clk) disable iff (reset)
        !started |-> !any_fetch_valid && !dmem_store.valid && !done)
        else flag_error("core active before start");

    for (genvar w = 0; w < WARPS; w++) begin : g_fetch_check
        a_fetch_addr: assert property (@(posedge clk) disable iff (reset)
            imem_req[w].valid |-> fetch_addr_good[w])
            else flag_error($sformatf("warp %0d fetch address out of order", w));
        a_fetch_hold: assert property (@(posedge clk) disable iff (reset)
            imem_req[w].valid && !imem_ready[w] |=>
                imem_req[w].valid && $stable(imem_req[w].address))
            else flag_error($sformatf("warp %0d fetch request changed before ready", w));
        a_fetch_release: assert property (@(posedge clk) disable iff (reset)
            imem_req[w].valid && imem_ready[w] |=> !imem_req[w].valid)
            else flag_error($sformatf("warp %0d fetch valid held after transfer", w));
        a_fetch_inactive: assert property (@(posedge clk) disable iff (reset)
            w >= kernel_config.num_warps |-> !imem_req[w].valid)
            else flag_error($sformatf("inactive warp %0d requested a fetch", w));
    end

    a_store_value: assert property (@(posedge clk) disable iff (reset)
        dmem_store.valid && dmem_ready |-> store_good)
        else flag_error("store address or data mismatch");

    a_store_hold: assert property (@(posedge clk) disable iff (reset)
        dmem_store.valid && !dmem_ready |=> dmem_store.valid && $stable(dmem_store))
        else flag_error("store request changed while stalled");

    a_done_after_stores: assert property (@(posedge clk) disable iff (reset)
        done |-> stores_all_done)
        else flag_error("done without two stores per active warp");

    a_quiet_after_done: assert property (@(posedge clk) disable iff (reset)
        done |-> !any_fetch_valid && !dmem_store.valid)
        else flag_error("request raised after done");

    task automatic wait_for_reset_release();
        int cycles;
        cycles = 0;
        while (reset && cycles < RESET_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (reset) begin
            $display("Timeout, reset still high after %0d cycles", cycles);
            timeout_count++;
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        soft_reset <= 1'b1;
        started <= 1'b0;
        repeat (3) @(posedge clk);
        soft_reset <= 1'b0;
        wait_for_reset_release();
    endtask

    task automatic run_kernel(input core_pkg::iaddr_t base, input logic [2:0] warps,
                              input core_pkg::data_t bid);
        int cycles;
        @(posedge clk);
        kernel_config.base_address <= base;
        kernel_config.num_warps <= warps;
        block_id <= bid;
        repeat (2) @(posedge clk);
        start <= 1'b1;
        started <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        cycles = 0;
        while (!done && cycles < DONE_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (done) begin
            // Give the after-done checks some cycles
            repeat (20) @(posedge clk);
        end else begin
            $display("Timeout, done did not rise within %0d cycles", DONE_TIMEOUT);
            timeout_count++;
        end
    endtask

    initial begin
        start <= 1'b0;
        started <= 1'b0;
        soft_reset <= 1'b0;
        block_id <= '0;
        kernel_config <= '0;
        imem_ready <= '0;
        dmem_ready <= 1'b0;
        for (int w = 0; w < WARPS; w++) begin
            imem_data[w] <= '0;
        end

        wait_for_reset_release();
        if (timeout_count == 0) begin
            run_kernel(8'h20, 3'd4, 16'd5);
        end
        // Second run with half the warps and another block
        if (timeout_count == 0) begin
            apply_reset();
            run_kernel(8'h80, 3'd2, 16'd11);
        end

        $display("Checks finished with %0d errors and %0d timeouts", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- flist.f
core_pkg.sv
fetcher.sv
decoder.sv
warp_scheduler.sv
vector_reg_file.sv
vector_alu.sv
store_unit.sv
compute_core.sv
tb_clock_gen.sv
tb_compute_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_compute_core \
    -f flist.f --Mdir obj_dir -o sim_compute_core
./obj_dir/sim_compute_core | tee sim.log

if grep -qx "sim passed" sim.log; then
    exit 0
fi
echo "Simulation reported failure, see sim.log"
exit 1
